// File: hw/rv_core_pkg.sv
// shared types for the four-stage RV32I subset core
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    localparam xlen_t EBREAK_INSTR = 32'h0010_0073;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        CTL_NONE, CTL_BEQ, CTL_BNE, CTL_JAL, CTL_EBREAK, CTL_ILLEGAL
    } ctl_kind_e;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        alu_op_e   alu_op;
        xlen_t     src_a;
        xlen_t     src_b;
        xlen_t     rs2_val;  // branch compare operand
        xlen_t     imm;
        reg_addr_t rd;
        logic      rd_we;
        ctl_kind_e ctl_kind;
    } exec_pkt_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        reg_addr_t rd;
        logic      rd_we;
        xlen_t     wdata;
        logic      illegal;
        logic      ebreak;
    } retire_t;

    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

endpackage

`default_nettype wire

// File: hw/rv_fetch.sv
// instruction fetch with pc and a Wishbone classic read master
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
    parameter rv_core_pkg::xlen_t RESET_PC = '0
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  rv_core_pkg::redirect_t      redirect_i,
    input  wire logic                   halt_i,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output rv_core_pkg::xlen_t          wb_adr_o,
    input  rv_core_pkg::xlen_t          wb_dat_i,
    input  wire logic                   wb_ack_i,
    output rv_core_pkg::fetch_pkt_t     fetch_o
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e             state_q;
    rv_core_pkg::xlen_t pc_q;      // address of the next cycle to issue
    rv_core_pkg::xlen_t adr_q;     // address of the open cycle
    logic               squash_q;  // redirect seen while cycle open
    logic               stop_q;    // ebreak fetched, wait for halt or redirect
    rv_core_pkg::xlen_t next_pc;
    logic               take;
    logic               start;

    assign next_pc = redirect_i.valid ? redirect_i.target : pc_q;
    assign take    = (state_q == BUSY) && wb_ack_i && !squash_q && !redirect_i.valid;
    // an older redirect reopens fetch after a shadowed ebreak
    assign start   = (state_q == IDLE) && !halt_i && (!stop_q || redirect_i.valid);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            pc_q     <= RESET_PC;
            squash_q <= 1'b0;
            stop_q   <= 1'b0;
        end else begin
            pc_q <= start ? next_pc + 32'd4 : next_pc;
            if (redirect_i.valid) begin
                stop_q <= 1'b0;
            end else if (take && wb_dat_i == rv_core_pkg::EBREAK_INSTR) begin
                stop_q <= 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= BUSY;
                        adr_q   <= next_pc;
                    end
                end
                BUSY: begin
                    if (wb_ack_i) begin
                        state_q  <= IDLE;  // cyc drops for one cycle
                        squash_q <= 1'b0;
                    end else if (redirect_i.valid) begin
                        squash_q <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign wb_cyc_o = (state_q == BUSY);
    assign wb_stb_o = (state_q == BUSY);
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = adr_q;

    assign fetch_o.valid = take;
    assign fetch_o.pc    = adr_q;
    assign fetch_o.instr = wb_dat_i;

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
// IF/ID register, instruction decode, immediates and operand forwarding
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  rv_core_pkg::fetch_pkt_t     fetch_i,
    input  rv_core_pkg::redirect_t      redirect_i,
    input  wire logic                   ex_fwd_we_i,
    input  rv_core_pkg::reg_addr_t      ex_fwd_rd_i,
    input  rv_core_pkg::xlen_t          ex_fwd_data_i,
    output rv_core_pkg::reg_addr_t      rf_raddr_a_o,
    output rv_core_pkg::reg_addr_t      rf_raddr_b_o,
    input  rv_core_pkg::xlen_t          rf_rdata_a_i,
    input  rv_core_pkg::xlen_t          rf_rdata_b_i,
    output rv_core_pkg::exec_pkt_t      exec_o
);

    rv_core_pkg::fetch_pkt_t if_id_q;
    rv_core_pkg::xlen_t      instr;
    rv_core_pkg::opcode_e    opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    rv_core_pkg::reg_addr_t  rs1;
    rv_core_pkg::reg_addr_t  rs2;
    rv_core_pkg::reg_addr_t  rd;
    rv_core_pkg::xlen_t      imm_i, imm_u, imm_b, imm_j;
    rv_core_pkg::xlen_t      rs1_val, rs2_val;
    logic                    alt;
    logic                    f7_ok;
    rv_core_pkg::alu_op_e    f3_op;
    rv_core_pkg::alu_op_e    alu_op;
    rv_core_pkg::ctl_kind_e  kind;
    rv_core_pkg::xlen_t      imm;
    logic                    rd_wr;
    logic                    use_imm;

    always_ff @(posedge clk_i) begin
        if_id_q <= fetch_i;
        if (!rst_n_i) begin
            if_id_q.valid <= 1'b0;
        end
    end

    assign instr  = if_id_q.instr;
    assign opcode = rv_core_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // execute result wins over the register file
    assign rf_raddr_a_o = rs1;
    assign rf_raddr_b_o = rs2;
    assign rs1_val = (ex_fwd_we_i && ex_fwd_rd_i == rs1 && rs1 != '0) ? ex_fwd_data_i
                                                                      : rf_rdata_a_i;
    assign rs2_val = (ex_fwd_we_i && ex_fwd_rd_i == rs2 && rs2 != '0) ? ex_fwd_data_i
                                                                      : rf_rdata_b_i;

    // bit 30 selects sub only for OP, sra for both
    assign alt   = instr[30] && (funct3 == 3'b101 || opcode == rv_core_pkg::OPC_OP);
    assign f7_ok = (funct7 == 7'h00) || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  f3_op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  f3_op = rv_core_pkg::ALU_SLL;
            3'b010:  f3_op = rv_core_pkg::ALU_SLT;
            3'b011:  f3_op = rv_core_pkg::ALU_SLTU;
            3'b100:  f3_op = rv_core_pkg::ALU_XOR;
            3'b101:  f3_op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  f3_op = rv_core_pkg::ALU_OR;
            default: f3_op = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        kind    = rv_core_pkg::CTL_ILLEGAL;  // anything unmatched
        alu_op  = rv_core_pkg::ALU_ADD;
        imm     = imm_i;
        rd_wr   = 1'b0;
        use_imm = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                alu_op = f3_op;
                if (f7_ok) begin
                    kind  = rv_core_pkg::CTL_NONE;
                    rd_wr = 1'b1;
                end
            end
            rv_core_pkg::OPC_OP_IMM: begin
                alu_op  = f3_op;
                use_imm = 1'b1;
                if (funct3[1:0] != 2'b01 || f7_ok) begin  // shifts check funct7
                    kind  = rv_core_pkg::CTL_NONE;
                    rd_wr = 1'b1;
                end
            end
            rv_core_pkg::OPC_LUI: begin
                kind    = rv_core_pkg::CTL_NONE;
                alu_op  = rv_core_pkg::ALU_PASS_B;
                imm     = imm_u;
                use_imm = 1'b1;
                rd_wr   = 1'b1;
            end
            rv_core_pkg::OPC_BRANCH: begin
                imm = imm_b;
                if (funct3 == 3'b000) kind = rv_core_pkg::CTL_BEQ;
                if (funct3 == 3'b001) kind = rv_core_pkg::CTL_BNE;
            end
            rv_core_pkg::OPC_JAL: begin
                kind  = rv_core_pkg::CTL_JAL;
                imm   = imm_j;
                rd_wr = 1'b1;
            end
            rv_core_pkg::OPC_SYSTEM: begin
                if (instr == rv_core_pkg::EBREAK_INSTR) kind = rv_core_pkg::CTL_EBREAK;
            end
            default: kind = rv_core_pkg::CTL_ILLEGAL;
        endcase
    end

    assign exec_o.valid    = if_id_q.valid && !redirect_i.valid;  // killed by taken branch
    assign exec_o.pc       = if_id_q.pc;
    assign exec_o.alu_op   = alu_op;
    assign exec_o.src_a    = rs1_val;
    assign exec_o.src_b    = use_imm ? imm : rs2_val;
    assign exec_o.rs2_val  = rs2_val;
    assign exec_o.imm      = imm;
    assign exec_o.rd       = rd;
    assign exec_o.rd_we    = rd_wr && rd != '0;
    assign exec_o.ctl_kind = kind;

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
// 32 x 32 register file, x0 reads zero, same-cycle write visible on read
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire logic               clk_i,
    input  wire logic               we_i,
    input  rv_core_pkg::reg_addr_t  waddr_i,
    input  rv_core_pkg::reg_addr_t  raddr_a_i,
    input  rv_core_pkg::reg_addr_t  raddr_b_i,
    input  rv_core_pkg::xlen_t      wdata_i,
    output rv_core_pkg::xlen_t      rdata_a_o,
    output rv_core_pkg::xlen_t      rdata_b_o
);

    rv_core_pkg::xlen_t regs_q [32];

    always_ff @(posedge clk_i) begin
        if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // write-through on matching address
    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       (we_i && waddr_i == raddr_a_i) ? wdata_i : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       (we_i && waddr_i == raddr_b_i) ? wdata_i : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
// ID/EX register, ALU, branch resolution and the writeback/retire register
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  rv_core_pkg::exec_pkt_t      exec_i,
    output rv_core_pkg::redirect_t      redirect_o,
    output logic                        fwd_we_o,
    output rv_core_pkg::reg_addr_t      fwd_rd_o,
    output rv_core_pkg::xlen_t          fwd_data_o,
    output logic                        rf_we_o,
    output rv_core_pkg::reg_addr_t      rf_waddr_o,
    output rv_core_pkg::xlen_t          rf_wdata_o,
    output rv_core_pkg::retire_t        retire_o,
    output logic                        halt_o
);

    rv_core_pkg::exec_pkt_t ex_q;
    rv_core_pkg::retire_t   wb_q;
    logic                   halt_q;
    rv_core_pkg::xlen_t     alu_res;
    rv_core_pkg::xlen_t     result;
    logic [4:0]             shamt;
    logic                   equal;
    logic                   taken;

    always_ff @(posedge clk_i) begin
        ex_q <= exec_i;
        if (!rst_n_i) begin
            ex_q.valid <= 1'b0;
        end
    end

    assign shamt = ex_q.src_b[4:0];

    always_comb begin
        case (ex_q.alu_op)
            rv_core_pkg::ALU_ADD:    alu_res = ex_q.src_a + ex_q.src_b;
            rv_core_pkg::ALU_SUB:    alu_res = ex_q.src_a - ex_q.src_b;
            rv_core_pkg::ALU_AND:    alu_res = ex_q.src_a & ex_q.src_b;
            rv_core_pkg::ALU_OR:     alu_res = ex_q.src_a | ex_q.src_b;
            rv_core_pkg::ALU_XOR:    alu_res = ex_q.src_a ^ ex_q.src_b;
            rv_core_pkg::ALU_SLT:    alu_res = {31'd0, $signed(ex_q.src_a) < $signed(ex_q.src_b)};
            rv_core_pkg::ALU_SLTU:   alu_res = {31'd0, ex_q.src_a < ex_q.src_b};
            rv_core_pkg::ALU_SLL:    alu_res = ex_q.src_a << shamt;
            rv_core_pkg::ALU_SRL:    alu_res = ex_q.src_a >> shamt;
            rv_core_pkg::ALU_SRA:    alu_res = $signed(ex_q.src_a) >>> shamt;
            rv_core_pkg::ALU_PASS_B: alu_res = ex_q.src_b;
            default:                 alu_res = '0;
        endcase
    end

    // jal links pc + 4
    assign result = (ex_q.ctl_kind == rv_core_pkg::CTL_JAL) ? ex_q.pc + 32'd4 : alu_res;

    assign equal = (ex_q.src_a == ex_q.rs2_val);
    assign taken = ex_q.valid && ((ex_q.ctl_kind == rv_core_pkg::CTL_BEQ && equal) ||
                                  (ex_q.ctl_kind == rv_core_pkg::CTL_BNE && !equal) ||
                                  ex_q.ctl_kind == rv_core_pkg::CTL_JAL);

    assign redirect_o.valid  = taken;
    assign redirect_o.target = ex_q.pc + ex_q.imm;

    assign fwd_we_o   = ex_q.valid && ex_q.rd_we;
    assign fwd_rd_o   = ex_q.rd;
    assign fwd_data_o = result;

    always_ff @(posedge clk_i) begin
        wb_q.pc      <= ex_q.pc;
        wb_q.rd      <= ex_q.rd;
        wb_q.rd_we   <= ex_q.rd_we;
        wb_q.wdata   <= result;
        wb_q.illegal <= (ex_q.ctl_kind == rv_core_pkg::CTL_ILLEGAL);
        wb_q.ebreak  <= (ex_q.ctl_kind == rv_core_pkg::CTL_EBREAK);
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
            halt_q     <= 1'b0;
        end else begin
            wb_q.valid <= ex_q.valid;
            if (ex_q.valid && ex_q.ctl_kind == rv_core_pkg::CTL_EBREAK) begin
                halt_q <= 1'b1;  // sticky until reset
            end
        end
    end

    assign rf_we_o    = wb_q.valid && wb_q.rd_we;
    assign rf_waddr_o = wb_q.rd;
    assign rf_wdata_o = wb_q.wdata;
    assign retire_o   = wb_q;
    assign halt_o     = halt_q;

endmodule

`default_nettype wire

// File: hw/rv_core_top.sv
// core top level joining fetch, decode, register file and execute
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter rv_core_pkg::xlen_t RESET_PC = '0
) (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output rv_core_pkg::xlen_t      wb_adr_o,
    input  rv_core_pkg::xlen_t      wb_dat_i,
    input  wire logic               wb_ack_i,
    output rv_core_pkg::retire_t    retire_o,
    output logic                    halt_o
);

    rv_core_pkg::fetch_pkt_t fetch_pkt;
    rv_core_pkg::exec_pkt_t  exec_pkt;
    rv_core_pkg::redirect_t  redirect;
    logic                    fwd_we;
    rv_core_pkg::reg_addr_t  fwd_rd;
    rv_core_pkg::xlen_t      fwd_data;
    rv_core_pkg::reg_addr_t  rf_raddr_a, rf_raddr_b, rf_waddr;
    rv_core_pkg::xlen_t      rf_rdata_a, rf_rdata_b, rf_wdata;
    logic                    rf_we;

    rv_fetch #(
        .RESET_PC   (RESET_PC)
    ) u_fetch (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect),
        .halt_i     (halt_o),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i),
        .fetch_o    (fetch_pkt)
    );

    rv_decode u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_i       (fetch_pkt),
        .redirect_i    (redirect),
        .ex_fwd_we_i   (fwd_we),
        .ex_fwd_rd_i   (fwd_rd),
        .ex_fwd_data_i (fwd_data),
        .rf_raddr_a_o  (rf_raddr_a),
        .rf_raddr_b_o  (rf_raddr_b),
        .rf_rdata_a_i  (rf_rdata_a),
        .rf_rdata_b_i  (rf_rdata_b),
        .exec_o        (exec_pkt)
    );

    rv_regfile u_regfile (
        .clk_i     (clk_i),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .wdata_i   (rf_wdata),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b)
    );

    rv_execute u_execute (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .exec_i     (exec_pkt),
        .redirect_o (redirect),
        .fwd_we_o   (fwd_we),
        .fwd_rd_o   (fwd_rd),
        .fwd_data_o (fwd_data),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .retire_o   (retire_o),
        .halt_o     (halt_o)
    );

endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
// testbench for the RV32I subset core with a Wishbone instruction memory and retire checker
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam rv_core_pkg::xlen_t RESET_PC = 32'h0000_0040;
    localparam integer TIMEOUT = 200;  // cycles per wait
    localparam integer QUIET = 40;     // cycles watched after halt

    logic                   clk;
    logic                   rst_n;
    logic                   wb_ack;
    rv_core_pkg::xlen_t     wb_dat;
    logic                   wb_cyc, wb_stb, wb_we;
    rv_core_pkg::xlen_t     wb_adr;
    rv_core_pkg::retire_t   retire;
    logic                   halt;

    rv_core_pkg::xlen_t     cases [0:511];
    rv_core_pkg::xlen_t     mem [0:255];
    integer                 seed;
    integer                 wait_cnt;
    integer                 pos;
    rv_core_pkg::xlen_t     name;  // four ascii chars

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_ack_i (wb_ack),
        .retire_o (retire),
        .halt_o   (halt)
    );

    always #10 clk = ~clk;

    // instruction memory with 0 to 3 random wait states before each ack
    always @(posedge clk) begin
        #1;
        if (rst_n) begin
            check("wb stb", {31'd0, wb_cyc}, {31'd0, wb_stb});  // strobe follows cyc
        end
        if (!rst_n || wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            check("wb we", 32'd0, {31'd0, wb_we});  // fetch only reads
            if (wait_cnt == 0) begin
                wb_dat   = mem[wb_adr[9:2]];
                wb_ack   = 1'b1;
                wait_cnt = {$random(seed)} % 4;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    task automatic check(input string what, input rv_core_pkg::xlen_t exp,
                         input rv_core_pkg::xlen_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic give_up(input string what);
        $display("test %s: %s", name, what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic wait_retire();
        integer n;
        n = 0;
        @(posedge clk);
        #1;
        while (!retire.valid) begin
            n = n + 1;
            if (n > TIMEOUT) give_up("no instruction retired within the timeout");
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_test();
        integer             nprog;
        integer             nexp;
        integer             i;
        integer             n;
        rv_core_pkg::xlen_t flags;
        name  = cases[pos];
        nprog = cases[pos+1];
        nexp  = cases[pos+2];
        pos   = pos + 3;
        rst_n = 1'b0;
        for (i = 0; i < 256; i = i + 1) begin
            mem[i] = {i[23:0], 8'h00};  // illegal opcode everywhere
        end
        for (i = 0; i < nprog; i = i + 1) begin
            mem[RESET_PC[9:2] + i] = cases[pos+i];
        end
        pos = pos + nprog;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (i = 0; i < nexp; i = i + 1) begin
            wait_retire();
            flags = {15'd0, retire.rd_we ? retire.rd : 5'd0, 3'd0, retire.rd_we,
                     3'd0, retire.illegal, 3'd0, retire.ebreak};
            check("pc", cases[pos], retire.pc);
            check("flags", cases[pos+2], flags);
            if (cases[pos+2][8]) check("wdata", cases[pos+1], retire.wdata);
            pos = pos + 3;
        end
        n = 0;
        while (!halt) begin
            n = n + 1;
            if (n > TIMEOUT) give_up("halt never went high after ebreak");
            @(posedge clk);
            #1;
        end
        for (i = 0; i < QUIET; i = i + 1) begin
            @(posedge clk);
            #1;
            check("retire after halt", 32'd0, {31'd0, retire.valid});
            check("bus cycle after halt", 32'd0, {31'd0, wb_cyc});
        end
        $display("test %s done", name);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_ack   = 1'b0;
        wb_dat   = '0;
        seed     = 74686;
        wait_cnt = 0;
        pos      = 0;
        name     = "none";
        $readmemh("testbench/rv_core_cases.txt", cases);
        while (cases[pos] !== 32'd0) begin
            run_test();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/rv_core_cases.txt
// block: name(ascii) nprog nexp, program words, then records: pc wdata flags
// flags = rd<<12 | rd_we<<8 | illegal<<4 | ebreak, a zero name ends the file
616c7520 16 16
FF900093 00300113 002081B3 40208233 0020F2B3 0020E333 0020C3B3 0020A433
0020B4B3 00211533 0020D5B3 4020D633 0F00C693 FF80A713 FFF13793 4010D813
123458B7 0FF0F913 10016993 00411A13 01C0DA93 00100073
40 FFFFFFF9 00001100  44 00000003 00002100  48 FFFFFFFC 00003100
4C FFFFFFF6 00004100  50 00000001 00005100  54 FFFFFFFB 00006100
58 FFFFFFFA 00007100  5C 00000001 00008100  60 00000000 00009100
64 00000018 0000A100  68 1FFFFFFF 0000B100  6C FFFFFFFF 0000C100
70 FFFFFF09 0000D100  74 00000000 0000E100  78 00000001 0000F100
7C FFFFFFFC 00010100  80 12345000 00011100  84 000000F9 00012100
88 00000103 00013100  8C 00000030 00014100  90 0000000F 00015100
94 00000000 00000001
64657020 7 7
00500093 00108093 00108133 001101B3 00708013 00300233 00100073
40 00000005 00001100  44 00000006 00001100  48 0000000C 00002100
4C 00000012 00003100  50 00000000 00000000  54 00000012 00004100
58 00000000 00000001
63746c20 A 6
00200093 00108663 00100113 00200113 00109463 00C002EF 00100193 00200193
00028313 00100073
40 00000002 00001100  44 00000000 00000000  50 00000000 00000000
54 00000058 00005100  60 00000058 00006100  64 00000000 00000001
696c6c20 4 4
00900293 0000028B 00028313 00100073
40 00000009 00005100  44 00000000 00000010  48 00000009 00006100
4C 00000000 00000001
00000000

// File: compile.f
hw/rv_core_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core_top.sv
testbench/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_rv_core
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
